//--- Makefile
# Verilator flow for the address generator testbench
VERILATOR ?= verilator
TOP       ?= tb_addrgen
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass or fail comes from the log, not the exit code of the pipe
run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- addrgen_defs.svh
// Shared sizing macros for the vector memory address generator
// Included by the package and by every RTL unit that needs a width
`ifndef ADDRGEN_DEFS_SVH
`define ADDRGEN_DEFS_SVH

//////////////////////////////////////////////////
// Bus geometry
//////////////////////////////////////////////////

// Byte address width on the AR/AW channels
`define ADDRGEN_ADDR_W 32
// Bus data width, one beat is DATA_W/8 bytes
`define ADDRGEN_DATA_W 64

//////////////////////////////////////////////////
// Burst limits
//////////////////////////////////////////////////

// Longest INCR burst in beats
`define ADDRGEN_MAX_BEATS 256
// Bursts never cross a 4 KiB page
`define ADDRGEN_PAGE_BITS 12
// Vector length counter width in elements
`define ADDRGEN_LEN_W 16

`endif

//--- filelist.f
+incdir+.
+incdir+sim
verilog/addrgen_pkg.sv
verilog/vmem_req_ctrl.sv
verilog/burst_planner.sv
verilog/ax_issue.sv
verilog/lsu_req_fifo.sv
verilog/addrgen.sv
sim/tb_addrgen.sv

//--- sim/tb_addrgen_model.svh
// Reference model and typed compare tasks for the address generator testbench
// Included inside tb_addrgen, fills the expected AX and LSU queue streams
`ifndef TB_ADDRGEN_MODEL_SVH
`define TB_ADDRGEN_MODEL_SVH

// Loads go out on AR, stores on AW
function automatic bit op_reads(addrgen_pkg::mem_op_e op);
  return (op == addrgen_pkg::VLE) || (op == addrgen_pkg::VLSE);
endfunction

// Expand one aligned request into the AX requests the DUT should issue
function automatic void expand_request(addrgen_pkg::vmem_req_t req);
  longint unsigned       beat_bytes;
  longint unsigned       page_bytes;
  longint unsigned       cur;
  longint unsigned       left;
  longint unsigned       span;
  longint unsigned       first_beat;
  longint unsigned       stop;
  longint unsigned       taken;
  addrgen_pkg::ax_req_t  ax;
  addrgen_pkg::lsu_req_t lsu;
  beat_bytes = `ADDRGEN_DATA_W / 8;
  page_bytes = 64'd1 << `ADDRGEN_PAGE_BITS;
  cur        = req.addr;
  left       = req.len;
  while (left != 0) begin
    ax.addr  = cur[`ADDRGEN_ADDR_W-1:0];
    ax.burst = 2'b01;
    if ((req.op == addrgen_pkg::VLE) || (req.op == addrgen_pkg::VSE)) begin
      // Bytes still wanted, capped at the longest burst
      span = left << req.vew;
      if (span > `ADDRGEN_MAX_BEATS * beat_bytes) span = `ADDRGEN_MAX_BEATS * beat_bytes;
      first_beat = cur - (cur % beat_bytes);
      stop       = cur + span - 1;
      stop       = stop - (stop % beat_bytes) + beat_bytes - 1;
      // Never leave the page of the first beat
      if ((stop / page_bytes) != (first_beat / page_bytes)) begin
        stop = (first_beat / page_bytes + 1) * page_bytes - 1;
      end
      ax.len  = 8'((stop - first_beat) / beat_bytes);
      ax.size = 3'($clog2(`ADDRGEN_DATA_W / 8));
      taken   = (stop - cur + 1) >> req.vew;
      left    = (left > taken) ? left - taken : 0;
      cur     = stop + 1;
    end else begin
      // Strided: one element per beat
      ax.len  = 8'd0;
      ax.size = 3'(req.vew);
      left    = left - 1;
      cur     = (cur + req.stride) & 64'hFFFF_FFFF;
    end
    lsu.addr    = ax.addr;
    lsu.len     = ax.len;
    lsu.size    = ax.size;
    lsu.is_load = op_reads(req.op);
    exp_ax.push_back(ax);
    exp_ax_load.push_back(op_reads(req.op));
    exp_lsu.push_back(lsu);
  end
endfunction

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////

task automatic check_ax(string name, addrgen_pkg::ax_req_t got, addrgen_pkg::ax_req_t exp);
  if (got !== exp) begin
    $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
    report_failure();
  end
endtask

task automatic check_lsu(string name, addrgen_pkg::lsu_req_t got, addrgen_pkg::lsu_req_t exp);
  if (got !== exp) begin
    $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
    report_failure();
  end
endtask

task automatic check_bit(string name, logic got, logic exp);
  if (got !== exp) begin
    $display("FAIL t=%0t %s got=%b exp=%b", $time, name, got, exp);
    report_failure();
  end
endtask

`endif

//--- sim/tb_addrgen.sv
// Testbench for the vector memory address generator
// Applies a table of requests, randomizes AX and LSU ready, and checks every
// issued AX request, queue entry and acknowledgment against the model
`timescale 1ns/1ns
`include "addrgen_defs.svh"

module tb_addrgen;

  localparam int CLK_PERIOD  = 8;
  localparam int DRIVE_DELAY = 1;
  localparam int RESET_CYCLES = 5;
  localparam int CYCLES_PER_TEST = 600;

  logic                   clk_i;
  logic                   rst_ni;
  addrgen_pkg::vmem_req_t pe_req_i;
  logic                   pe_req_valid_i;
  logic                   ar_ready_i;
  logic                   aw_ready_i;
  logic                   lsu_req_ready_i;
  logic                   pe_req_ready_o;
  logic                   ack_o;
  logic                   error_o;
  addrgen_pkg::ax_req_t   ar_o;
  logic                   ar_valid_o;
  addrgen_pkg::ax_req_t   aw_o;
  logic                   aw_valid_o;
  addrgen_pkg::lsu_req_t  lsu_req_o;
  logic                   lsu_req_valid_o;

  // Stimulus table and expected streams
  addrgen_pkg::vmem_req_t table_req [$];
  logic                   table_err [$];
  addrgen_pkg::ax_req_t   exp_ax [$];
  bit                     exp_ax_load [$];
  addrgen_pkg::lsu_req_t  exp_lsu [$];
  bit                     table_ready = 1'b0;
  int                     seed = 32'h9da2;
  int                     ack_count = 0;
  // AX valid seen last cycle without its handshake
  bit                     ax_waiting = 1'b0;
  bit                     ax_fire;

  addrgen u_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pe_req_i       (pe_req_i),
    .pe_req_valid_i (pe_req_valid_i),
    .ar_ready_i     (ar_ready_i),
    .aw_ready_i     (aw_ready_i),
    .lsu_req_ready_i(lsu_req_ready_i),
    .pe_req_ready_o (pe_req_ready_o),
    .ack_o          (ack_o),
    .error_o        (error_o),
    .ar_o           (ar_o),
    .ar_valid_o     (ar_valid_o),
    .aw_o           (aw_o),
    .aw_valid_o     (aw_valid_o),
    .lsu_req_o      (lsu_req_o),
    .lsu_req_valid_o(lsu_req_valid_o)
  );

  task automatic report_failure();
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first mismatch");
  endtask

  task automatic report_problem(string what);
    $display("t=%0t %s", $time, what);
    report_failure();
  endtask

  `include "tb_addrgen_model.svh"

  function automatic void add_entry(addrgen_pkg::mem_op_e op, logic [31:0] addr, int len,
                                    logic [31:0] stride, addrgen_pkg::vew_e vew, logic err);
    addrgen_pkg::vmem_req_t req;
    req.op     = op;
    req.addr   = addr;
    req.len    = 16'(len);
    req.stride = stride;
    req.vew    = vew;
    table_req.push_back(req);
    table_err.push_back(err);
  endfunction

  //////////////////////////////////////////////////
  // Clock, ready randomization, watchdog
  //////////////////////////////////////////////////

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin : ready_gen
    ar_ready_i      = 1'b0;
    aw_ready_i      = 1'b0;
    lsu_req_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #(DRIVE_DELAY);
      ar_ready_i      = ($random(seed) & 1) != 0;
      aw_ready_i      = ($random(seed) & 1) != 0;
      lsu_req_ready_i = ($random(seed) & 1) != 0;
    end
  end

  // Run length follows the table size
  initial begin : watchdog
    wait (table_ready);
    repeat (table_req.size() * CYCLES_PER_TEST) @(posedge clk_i);
    report_problem("Timeout, the request table did not complete in time");
  end

  //////////////////////////////////////////////////
  // Monitors, sampled mid-cycle
  //////////////////////////////////////////////////

  always @(negedge clk_i) begin : ax_monitor
    if (!rst_ni) begin
      ax_waiting = 1'b0;
    end else begin
      if (ax_waiting && !(ar_valid_o || aw_valid_o)) begin
        report_problem("AX valid dropped before its handshake");
      end
      ax_waiting = 1'b0;
      if (ar_valid_o || aw_valid_o) begin
        if (exp_ax.size() == 0) report_problem("AX valid raised with no request expected");
        check_bit("ar_valid_o", ar_valid_o, exp_ax_load[0]);
        check_bit("aw_valid_o", aw_valid_o, !exp_ax_load[0]);
        // Payload must equal the model on every valid cycle
        if (ar_valid_o) check_ax("ar_o", ar_o, exp_ax[0]);
        else check_ax("aw_o", aw_o, exp_ax[0]);
        // Direction rule against the queue head
        if (lsu_req_valid_o) check_bit("lsu_req_o.is_load", lsu_req_o.is_load, exp_ax_load[0]);
        ax_fire = (ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i);
        if (ax_fire) begin
          void'(exp_ax.pop_front());
          void'(exp_ax_load.pop_front());
        end else begin
          ax_waiting = 1'b1;
        end
      end
    end
  end

  always @(negedge clk_i) begin : lsu_monitor
    if (rst_ni && lsu_req_valid_o && lsu_req_ready_i) begin
      if (exp_lsu.size() == 0) report_problem("Queue output with no issued request");
      check_lsu("lsu_req_o", lsu_req_o, exp_lsu[0]);
      void'(exp_lsu.pop_front());
    end
  end

  always @(negedge clk_i) begin : ack_monitor
    if (rst_ni) begin
      if (error_o && !ack_o) report_problem("error_o raised without ack_o");
      if (ack_o) ack_count++;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic apply_request(int idx);
    addrgen_pkg::vmem_req_t req;
    logic                   exp_err;
    int                     wait_cycles;
    req         = table_req[idx];
    exp_err     = table_err[idx];
    wait_cycles = 0;
    @(posedge clk_i);
    #(DRIVE_DELAY);
    if (!exp_err) expand_request(req);
    pe_req_i       = req;
    pe_req_valid_i = 1'b1;
    @(negedge clk_i);
    while (!pe_req_ready_o) @(negedge clk_i);
    // Accepted on the coming edge
    @(posedge clk_i);
    #(DRIVE_DELAY);
    pe_req_valid_i = 1'b0;
    pe_req_i       = '0;
    do begin
      @(negedge clk_i);
      wait_cycles++;
    end while (!ack_o);
    check_bit("error_o", error_o, exp_err);
    // Misaligned requests are acked in the check cycle
    if (exp_err && wait_cycles != 1) report_problem("Error ack not one cycle after accept");
    if (exp_ax.size() != 0) report_problem("ack_o raised before all AX requests issued");
  endtask

  initial begin : main
    rst_ni         = 1'b0;
    pe_req_i       = '0;
    pe_req_valid_i = 1'b0;
    // Op, base, elements, stride, width, expected error
    add_entry(addrgen_pkg::VLE,  32'h0000_1000, 16,  32'h0,        addrgen_pkg::EW32, 1'b0);
    add_entry(addrgen_pkg::VSE,  32'h0000_2FC0, 32,  32'h0,        addrgen_pkg::EW64, 1'b0);
    add_entry(addrgen_pkg::VLE,  32'h0001_0000, 600, 32'h0,        addrgen_pkg::EW64, 1'b0);
    add_entry(addrgen_pkg::VSSE, 32'h0000_4000, 5,   32'h24,       addrgen_pkg::EW32, 1'b0);
    add_entry(addrgen_pkg::VLE,  32'h0000_5002, 4,   32'h0,        addrgen_pkg::EW32, 1'b1);
    add_entry(addrgen_pkg::VLSE, 32'h0000_6000, 6,   32'h10,       addrgen_pkg::EW16, 1'b0);
    add_entry(addrgen_pkg::VSE,  32'h0000_7003, 13,  32'h0,        addrgen_pkg::EW8,  1'b0);
    add_entry(addrgen_pkg::VLE,  32'h0000_8FF8, 3,   32'h0,        addrgen_pkg::EW64, 1'b0);
    add_entry(addrgen_pkg::VLSE, 32'h0000_A040, 4,   32'hFFFF_FFF8, addrgen_pkg::EW64, 1'b0);
    add_entry(addrgen_pkg::VSE,  32'h0000_B001, 8,   32'h0,        addrgen_pkg::EW16, 1'b1);
    table_ready = 1'b1;
    repeat (RESET_CYCLES - 1) @(posedge clk_i);
    @(negedge clk_i);
    // Everything quiet while in reset
    check_bit("pe_req_ready_o", pe_req_ready_o, 1'b0);
    check_bit("ack_o", ack_o, 1'b0);
    check_bit("error_o", error_o, 1'b0);
    check_bit("ar_valid_o", ar_valid_o, 1'b0);
    check_bit("aw_valid_o", aw_valid_o, 1'b0);
    check_bit("lsu_req_valid_o", lsu_req_valid_o, 1'b0);
    @(posedge clk_i);
    #(DRIVE_DELAY);
    rst_ni = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    check_bit("pe_req_ready_o", pe_req_ready_o, 1'b1);
    for (int i = 0; i < table_req.size(); i++) begin
      apply_request(i);
    end
    // Let the LSU side drain the queue
    while (exp_ax.size() != 0 || exp_lsu.size() != 0) @(negedge clk_i);
    @(negedge clk_i);
    check_bit("lsu_req_valid_o", lsu_req_valid_o, 1'b0);
    if (ack_count != table_req.size()) begin
      $display("t=%0t Saw %0d acks for %0d requests", $time, ack_count, table_req.size());
      report_failure();
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

//--- verilog/addrgen.sv
// Top of the vector memory address generator
// Connects the request front end, issue FSM, burst planner and LSU queue
`timescale 1ns/1ns
`include "addrgen_defs.svh"

module addrgen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  addrgen_pkg::vmem_req_t pe_req_i,
  input  logic                   pe_req_valid_i,
  input  logic                   ar_ready_i,
  input  logic                   aw_ready_i,
  input  logic                   lsu_req_ready_i,
  output logic                   pe_req_ready_o,
  output logic                   ack_o,
  output logic                   error_o,
  output addrgen_pkg::ax_req_t   ar_o,
  output logic                   ar_valid_o,
  output addrgen_pkg::ax_req_t   aw_o,
  output logic                   aw_valid_o,
  output addrgen_pkg::lsu_req_t  lsu_req_o,
  output logic                   lsu_req_valid_o
);

  ////////////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////////////

  logic                       issue_start;
  logic                       issue_done;
  addrgen_pkg::vmem_req_t     issue_req;
  // Planner loop
  logic [`ADDRGEN_ADDR_W-1:0] plan_addr;
  logic [`ADDRGEN_LEN_W-1:0]  plan_len;
  addrgen_pkg::vew_e          plan_vew;
  logic [`ADDRGEN_ADDR_W-1:0] plan_end;
  // Queue side
  logic                       fifo_push;
  addrgen_pkg::lsu_req_t      fifo_data;
  logic                       fifo_full;
  logic                       fifo_empty;

  vmem_req_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .pe_req_i      (pe_req_i),
    .pe_req_valid_i(pe_req_valid_i),
    .issue_done_i  (issue_done),
    .pe_req_ready_o(pe_req_ready_o),
    .ack_o         (ack_o),
    .error_o       (error_o),
    .issue_start_o (issue_start),
    .issue_req_o   (issue_req)
  );

  burst_planner u_planner (
    .addr_i    (plan_addr),
    .len_i     (plan_len),
    .vew_i     (plan_vew),
    .end_addr_o(plan_end)
  );

  ax_issue u_issue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .start_i         (issue_start),
    .req_i           (issue_req),
    .end_addr_i      (plan_end),
    .ar_ready_i      (ar_ready_i),
    .aw_ready_i      (aw_ready_i),
    .fifo_full_i     (fifo_full),
    .fifo_empty_i    (fifo_empty),
    .fifo_head_load_i(lsu_req_o.is_load),
    .addr_o          (plan_addr),
    .len_o           (plan_len),
    .vew_o           (plan_vew),
    .ar_o            (ar_o),
    .ar_valid_o      (ar_valid_o),
    .aw_o            (aw_o),
    .aw_valid_o      (aw_valid_o),
    .push_o          (fifo_push),
    .push_data_o     (fifo_data),
    .done_o          (issue_done)
  );

  // Ready from either LSU pops the head
  lsu_req_fifo u_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (fifo_push),
    .data_i (fifo_data),
    .pop_i  (lsu_req_ready_i),
    .data_o (lsu_req_o),
    .valid_o(lsu_req_valid_o),
    .full_o (fifo_full),
    .empty_o(fifo_empty)
  );

endmodule

//--- verilog/addrgen_pkg.sv
// Types shared by the address generator units and the testbench
// Holds the request, AX and queue structs plus the state and opcode enums
`include "addrgen_defs.svh"

package addrgen_pkg;

  //////////////////////////////////////////////////
  // Opcodes and element widths
  //////////////////////////////////////////////////

  // Unit-stride and strided loads/stores
  typedef enum logic [1:0] {
    VLE  = 2'd0,
    VSE  = 2'd1,
    VLSE = 2'd2,
    VSSE = 2'd3
  } mem_op_e;

  // Value is log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // AXI burst encoding, only INCR is generated
  localparam logic [1:0] BURST_INCR = 2'b01;

  //////////////////////////////////////////////////
  // Payloads
  //////////////////////////////////////////////////

  // Vector memory request from the sequencer
  typedef struct packed {
    mem_op_e                    op;
    logic [`ADDRGEN_ADDR_W-1:0] addr;
    logic [`ADDRGEN_LEN_W-1:0]  len;
    logic [`ADDRGEN_ADDR_W-1:0] stride;
    vew_e                       vew;
  } vmem_req_t;

  // Shared by AR and AW, len is beats minus one
  typedef struct packed {
    logic [`ADDRGEN_ADDR_W-1:0] addr;
    logic [7:0]                 len;
    logic [2:0]                 size;
    logic [1:0]                 burst;
  } ax_req_t;

  // Copy of an issued request for the load/store units
  typedef struct packed {
    logic [`ADDRGEN_ADDR_W-1:0] addr;
    logic [7:0]                 len;
    logic [2:0]                 size;
    logic                       is_load;
  } lsu_req_t;

  //////////////////////////////////////////////////
  // FSM states
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {ISSUE_IDLE, ISSUE_PLAN, ISSUE_REQUEST} issue_state_e;

  typedef enum logic [1:0] {CTRL_IDLE, CTRL_CHECK, CTRL_BUSY, CTRL_ACK} ctrl_state_e;

  // Loads go out on AR, stores on AW
  function automatic logic is_load(mem_op_e op);
    return (op == VLE) || (op == VLSE);
  endfunction

  // Unit-stride accesses become INCR bursts
  function automatic logic is_unit_stride(mem_op_e op);
    return (op == VLE) || (op == VSE);
  endfunction

endpackage

//--- verilog/ax_issue.sv
// AR/AW request issue FSM
// Walks a started request burst by burst (unit-stride) or element by element
// (strided), pushes a copy of each request to the LSU queue, pulses done at the end
`timescale 1ns/1ns
`include "addrgen_defs.svh"

module ax_issue (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       start_i,
  input  addrgen_pkg::vmem_req_t     req_i,
  input  logic [`ADDRGEN_ADDR_W-1:0] end_addr_i,
  input  logic                       ar_ready_i,
  input  logic                       aw_ready_i,
  input  logic                       fifo_full_i,
  input  logic                       fifo_empty_i,
  input  logic                       fifo_head_load_i,
  output logic [`ADDRGEN_ADDR_W-1:0] addr_o,
  output logic [`ADDRGEN_LEN_W-1:0]  len_o,
  output addrgen_pkg::vew_e          vew_o,
  output addrgen_pkg::ax_req_t       ar_o,
  output logic                       ar_valid_o,
  output addrgen_pkg::ax_req_t       aw_o,
  output logic                       aw_valid_o,
  output logic                       push_o,
  output addrgen_pkg::lsu_req_t      push_data_o,
  output logic                       done_o
);

  localparam int unsigned PB       = `ADDRGEN_PAGE_BITS;
  localparam int unsigned LEN_W    = `ADDRGEN_LEN_W;
  localparam int unsigned BEAT_LOG = $clog2(`ADDRGEN_DATA_W / 8);

  addrgen_pkg::issue_state_e  state_q, state_d;
  addrgen_pkg::vmem_req_t     cur_q, cur_d;
  logic [`ADDRGEN_ADDR_W-1:0] end_q, end_d;
  addrgen_pkg::ax_req_t       ax;
  logic                       load;
  logic                       unit;
  logic                       dir_ok;
  logic                       ax_valid;
  logic                       fire;
  logic [PB-1:0]              beat_span;
  logic [PB:0]                burst_bytes;
  logic [LEN_W-1:0]           burst_elems;

  assign load = addrgen_pkg::is_load(cur_q.op);
  assign unit = addrgen_pkg::is_unit_stride(cur_q.op);

  // Current position toward the burst planner
  assign addr_o = cur_q.addr;
  assign len_o  = cur_q.len;
  assign vew_o  = cur_q.vew;

  //////////////////////////////////////////////////
  // Burst geometry
  //////////////////////////////////////////////////

  // Byte distance from aligned start to end, shifted gives beats minus one
  assign beat_span = end_q[PB-1:0] - {cur_q.addr[PB-1:BEAT_LOG], {BEAT_LOG{1'b0}}};

  // Elements covered by this burst
  assign burst_bytes = {1'b0, end_q[PB-1:0]} - {1'b0, cur_q.addr[PB-1:0]} + 1'b1;
  assign burst_elems = LEN_W'(burst_bytes >> cur_q.vew);

  always_comb begin
    ax.addr  = cur_q.addr;
    ax.burst = addrgen_pkg::BURST_INCR;
    if (unit) begin
      ax.len  = beat_span[BEAT_LOG +: 8];
      ax.size = 3'(BEAT_LOG);
    end else begin
      // One beat per element, sized to the element
      ax.len  = 8'd0;
      ax.size = {1'b0, cur_q.vew};
    end
  end

  //////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////

  // Keep the direction until the queue has drained
  assign dir_ok   = fifo_empty_i || (fifo_head_load_i == load);
  assign ax_valid = (state_q == addrgen_pkg::ISSUE_REQUEST) && !fifo_full_i && dir_ok;

  assign ar_o       = ax;
  assign aw_o       = ax;
  assign ar_valid_o = ax_valid && load;
  assign aw_valid_o = ax_valid && !load;
  assign fire       = ax_valid && (load ? ar_ready_i : aw_ready_i);

  // Every accepted AX request is also queued for the LSUs
  assign push_o      = fire;
  assign push_data_o = '{addr: ax.addr, len: ax.len, size: ax.size, is_load: load};

  always_comb begin
    state_d = state_q;
    cur_d   = cur_q;
    end_d   = end_q;
    done_o  = 1'b0;
    case (state_q)
      addrgen_pkg::ISSUE_IDLE: begin
        if (start_i) begin
          cur_d   = req_i;
          state_d = addrgen_pkg::ISSUE_PLAN;
        end
      end
      addrgen_pkg::ISSUE_PLAN: begin
        end_d = end_addr_i;
        // Empty vector, nothing to issue
        if (cur_q.len == '0) begin
          done_o  = 1'b1;
          state_d = addrgen_pkg::ISSUE_IDLE;
        end else begin
          state_d = addrgen_pkg::ISSUE_REQUEST;
        end
      end
      addrgen_pkg::ISSUE_REQUEST: begin
        if (fire) begin
          if (unit) begin
            cur_d.addr = end_q + 1'b1;
            cur_d.len  = (cur_q.len > burst_elems) ? cur_q.len - burst_elems : '0;
            // Replan from the next beat
            state_d    = addrgen_pkg::ISSUE_PLAN;
          end else begin
            cur_d.addr = cur_q.addr + cur_q.stride;
            cur_d.len  = cur_q.len - 1'b1;
          end
          if (cur_d.len == '0) begin
            done_o  = 1'b1;
            state_d = addrgen_pkg::ISSUE_IDLE;
          end
        end
      end
      default: state_d = addrgen_pkg::ISSUE_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= addrgen_pkg::ISSUE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Working copy of the request and the planned burst end
  always_ff @(posedge clk_i) begin
    cur_q <= cur_d;
    end_q <= end_d;
  end

endmodule

//--- verilog/burst_planner.sv
// Burst end address calculation for unit-stride accesses
// Purely combinational, fed with the current address and remaining length
`timescale 1ns/1ns
`include "addrgen_defs.svh"

module burst_planner (
  input  logic [`ADDRGEN_ADDR_W-1:0] addr_i,
  input  logic [`ADDRGEN_LEN_W-1:0]  len_i,
  input  addrgen_pkg::vew_e          vew_i,
  output logic [`ADDRGEN_ADDR_W-1:0] end_addr_o
);

  localparam int unsigned AW         = `ADDRGEN_ADDR_W;
  localparam int unsigned PB         = `ADDRGEN_PAGE_BITS;
  localparam int unsigned BEAT_BYTES = `ADDRGEN_DATA_W / 8;
  localparam int unsigned BEAT_LOG   = $clog2(BEAT_BYTES);
  // Room for len shifted by the largest element size
  localparam int unsigned CNT_W      = `ADDRGEN_LEN_W + 4;
  localparam int unsigned MAX_BYTES  = `ADDRGEN_MAX_BEATS * BEAT_BYTES;

  logic [CNT_W-1:0] req_bytes;
  logic [CNT_W-1:0] burst_bytes;
  logic [AW-1:0]    last_byte;
  logic [AW-1:0]    start_aligned;
  logic [AW-1:0]    end_aligned;

  // Bytes still wanted by the instruction
  assign req_bytes = {4'b0000, len_i} << vew_i;

  // No burst beyond the beat limit
  assign burst_bytes = (req_bytes > CNT_W'(MAX_BYTES)) ? CNT_W'(MAX_BYTES) : req_bytes;

  assign last_byte     = addr_i + AW'(burst_bytes) - 1'b1;
  assign start_aligned = {addr_i[AW-1:BEAT_LOG], {BEAT_LOG{1'b0}}};

  // Round the last byte up to the end of its beat
  assign end_aligned = {last_byte[AW-1:BEAT_LOG], {BEAT_LOG{1'b1}}};

  //////////////////////////////////////////////////
  // 4 KiB page clip
  //////////////////////////////////////////////////

  always_comb begin
    end_addr_o = end_aligned;
    // Stop at the last byte of the start page
    if (end_aligned[AW-1:PB] != start_aligned[AW-1:PB]) begin
      end_addr_o = {start_aligned[AW-1:PB], {PB{1'b1}}};
    end
  end

endmodule

//--- verilog/lsu_req_fifo.sv
// Two-entry queue of issued AX requests toward the load/store units
// Push and pop are ignored when full or empty respectively
`timescale 1ns/1ns

module lsu_req_fifo (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_i,
  input  addrgen_pkg::lsu_req_t data_i,
  input  logic                  pop_i,
  output addrgen_pkg::lsu_req_t data_o,
  output logic                  valid_o,
  output logic                  full_o,
  output logic                  empty_o
);

  addrgen_pkg::lsu_req_t mem_q [2];
  logic                  wr_ptr_q;
  logic                  rd_ptr_q;
  logic [1:0]            count_q;
  logic                  do_push;
  logic                  do_pop;

  assign full_o  = (count_q == 2'd2);
  assign empty_o = (count_q == 2'd0);
  assign valid_o = !empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (do_push) wr_ptr_q <= !wr_ptr_q;
      if (do_pop)  rd_ptr_q <= !rd_ptr_q;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

//--- verilog/vmem_req_ctrl.sv
// Front end of the address generator
// Takes one request when idle, checks base alignment, starts the issue FSM
// and acknowledges completion or a misalignment error
`timescale 1ns/1ns
`include "addrgen_defs.svh"

module vmem_req_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  addrgen_pkg::vmem_req_t pe_req_i,
  input  logic                   pe_req_valid_i,
  input  logic                   issue_done_i,
  output logic                   pe_req_ready_o,
  output logic                   ack_o,
  output logic                   error_o,
  output logic                   issue_start_o,
  output addrgen_pkg::vmem_req_t issue_req_o
);

  addrgen_pkg::ctrl_state_e   state_q, state_d;
  addrgen_pkg::vmem_req_t     req_q;
  logic                       ready_q;
  logic [`ADDRGEN_ADDR_W-1:0] align_mask;
  logic                       misaligned;

  // Any address bit below the element size flags an error
  assign align_mask = ~({`ADDRGEN_ADDR_W{1'b1}} << req_q.vew);
  assign misaligned = |(req_q.addr & align_mask);

  assign pe_req_ready_o = ready_q;
  assign issue_req_o    = req_q;

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    ack_o         = 1'b0;
    error_o       = 1'b0;
    issue_start_o = 1'b0;
    case (state_q)
      addrgen_pkg::CTRL_IDLE: begin
        if (pe_req_valid_i && ready_q) begin
          state_d = addrgen_pkg::CTRL_CHECK;
        end
      end
      addrgen_pkg::CTRL_CHECK: begin
        // Misaligned requests are acked right away with no bus traffic
        if (misaligned) begin
          ack_o   = 1'b1;
          error_o = 1'b1;
          state_d = addrgen_pkg::CTRL_IDLE;
        end else begin
          issue_start_o = 1'b1;
          state_d       = addrgen_pkg::CTRL_BUSY;
        end
      end
      addrgen_pkg::CTRL_BUSY: begin
        if (issue_done_i) begin
          state_d = addrgen_pkg::CTRL_ACK;
        end
      end
      addrgen_pkg::CTRL_ACK: begin
        ack_o   = 1'b1;
        state_d = addrgen_pkg::CTRL_IDLE;
      end
      default: state_d = addrgen_pkg::CTRL_IDLE;
    endcase
  end

  // Ready follows the next state so it stays low while in reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= addrgen_pkg::CTRL_IDLE;
      ready_q <= 1'b0;
    end else begin
      state_q <= state_d;
      ready_q <= (state_d == addrgen_pkg::CTRL_IDLE);
    end
  end

  // Capture the accepted request
  always_ff @(posedge clk_i) begin
    if (pe_req_valid_i && ready_q) begin
      req_q <= pe_req_i;
    end
  end

endmodule
